/* hw/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    parameter int line_words = 8;
    parameter int num_sets = 16;

    // Byte address split as tag, set index, word offset, byte offset
    localparam int off_bits = 5;
    localparam int set_bits = 4;
    localparam int tag_bits = 32 - off_bits - set_bits;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [set_bits-1:0] set_idx_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [2:0] word_off_t;
    typedef logic [line_words-1:0] word_mask_t;
    typedef word_t [line_words-1:0] line_t;

    // Count is 1 to 8 instructions, all within one line
    typedef struct packed {
        addr_t      start_addr;
        logic [3:0] count;
    } fetch_req_t;

    typedef struct packed {
        line_t      line;
        word_mask_t mask;
        addr_t      start_addr;
    } fetch_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        RESPOND
    } ctrl_state_t;

    function automatic set_idx_t addr_set(addr_t addr);
        return addr[off_bits +: set_bits];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[31 -: tag_bits];
    endfunction

    function automatic word_off_t addr_off(addr_t addr);
        return addr[off_bits-1:2];
    endfunction

endpackage

`default_nettype wire

/* hw/icache_way_array.sv */
`default_nettype none

module icache_way_array
    import icache_pkg::*;
#(
    parameter int num_sets = icache_pkg::num_sets
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_en,
    input  set_idx_t   rd_set,
    input  tag_t       rd_tag,
    output logic [1:0] hit,
    output logic       hit_way,
    output line_t      rd_line,
    output logic       victim_way,
    input  logic       wr_en,
    input  logic       wr_way,
    input  set_idx_t   wr_set,
    input  tag_t       wr_tag,
    input  line_t      wr_line
);

    tag_t  tag_mem  [2][num_sets];
    line_t data_mem [2][num_sets];

    logic [1:0][num_sets-1:0] valid_q;
    // One bit per set, points at the least recently used way
    logic [num_sets-1:0] lru_q;

    logic       rd_valid_q;
    set_idx_t   rd_set_q;
    tag_t       rd_tag_q;
    logic [1:0] way_valid_q;
    tag_t       way_tag_q  [2];
    line_t      way_line_q [2];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_en && wr_way == 1'(w)) begin
                tag_mem[w][wr_set]  <= wr_tag;
                data_mem[w][wr_set] <= wr_line;
            end
            if (rd_en) begin
                way_tag_q[w]  <= tag_mem[w][rd_set];
                way_line_q[w] <= data_mem[w][rd_set];
            end
        end
        // Compare tag and set travel with the read
        if (rd_en) begin
            rd_tag_q <= rd_tag;
            rd_set_q <= rd_set;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= '0;
            lru_q       <= '0;
            rd_valid_q  <= 1'b0;
            way_valid_q <= '0;
        end else begin
            rd_valid_q <= rd_en;
            if (rd_en) begin
                way_valid_q <= {valid_q[1][rd_set], valid_q[0][rd_set]};
            end
            if (wr_en) begin
                valid_q[wr_way][wr_set] <= 1'b1;
                lru_q[wr_set]           <= ~wr_way;
            end else if (|hit) begin
                lru_q[rd_set_q] <= ~hit_way;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = rd_valid_q && way_valid_q[w] && (way_tag_q[w] == rd_tag_q);
        end
    end

    assign hit_way    = hit[1];
    assign rd_line    = way_line_q[hit_way];
    assign victim_way = lru_q[rd_set_q];

endmodule

`default_nettype wire

/* hw/refill_counter.sv */
`default_nettype none

module refill_counter
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  logic      beat,
    output word_off_t beat_idx,
    output logic      last_beat
);

    word_off_t count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else if (beat) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Next word slot of the line
    assign beat_idx = count_q;

    // Final beat of a full line, wraps the count back to zero
    assign last_beat = beat && (count_q == word_off_t'(line_words - 1));

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int num_sets = icache_pkg::num_sets
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_en,
    input  fetch_req_t  req,
    output logic        req_ready,
    input  logic        flush,
    input  logic        stall,
    output logic        resp_valid,
    output fetch_resp_t resp,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ready,
    input  logic        mem_valid,
    input  word_t       mem_data,
    input  logic        mem_last,
    output logic        rd_en,
    output set_idx_t    rd_set,
    output tag_t        rd_tag,
    input  logic [1:0]  hit,
    input  logic        hit_way,
    input  line_t       rd_line,
    input  logic        victim_way,
    output logic        wr_en,
    output logic        wr_way,
    output set_idx_t    wr_set,
    output tag_t        wr_tag,
    output line_t       wr_line,
    output logic        clear,
    output logic        beat,
    input  word_off_t   beat_idx,
    input  logic        last_beat
);

    typedef struct packed {
        line_t line;
        logic  way;
        logic  flushed;
    } miss_buf_t;

    ctrl_state_t state_q;
    ctrl_state_t state_next;
    fetch_req_t  req_q;
    miss_buf_t   miss_q;

    logic      lookup_hit;
    logic      lookup_hold;
    logic      accept;
    logic      refill_done;
    word_off_t start_off;
    line_t     src_line;
    line_t     fill_line;

    // Set index width is fixed by the address split
    if (num_sets != (1 << $bits(set_idx_t))) begin : g_sets_check
        $error("icache_ctrl: num_sets does not match the set index width");
    end

    assign lookup_hit  = (state_q == LOOKUP) && hit[hit_way];
    assign lookup_hold = lookup_hit && stall;
    assign req_ready   = (state_q == IDLE) || (lookup_hit && !stall && !flush);
    assign accept      = req_en && req_ready;

    // Re-read the buffered block while a hit is stalled
    assign rd_en  = accept || lookup_hold;
    assign rd_set = accept ? addr_set(req.start_addr) : addr_set(req_q.start_addr);
    assign rd_tag = accept ? addr_tag(req.start_addr) : addr_tag(req_q.start_addr);

    assign mem_req     = (state_q == MISS);
    assign mem_addr    = {req_q.start_addr[31:off_bits], {off_bits{1'b0}}};
    assign clear       = (state_q == MISS);
    assign beat        = (state_q == REFILL) && mem_valid;
    assign refill_done = beat && mem_last;

    // Last word goes straight into the array write
    always_comb begin
        fill_line           = miss_q.line;
        fill_line[beat_idx] = mem_data;
    end

    assign wr_en   = last_beat;
    assign wr_way  = miss_q.way;
    assign wr_set  = addr_set(req_q.start_addr);
    assign wr_tag  = addr_tag(req_q.start_addr);
    assign wr_line = fill_line;

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (flush) begin
                    state_next = IDLE;
                end else if (!lookup_hit) begin
                    state_next = MISS;
                end else if (!stall && !accept) begin
                    state_next = IDLE;
                end
            end
            MISS: begin
                if (mem_ready) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (refill_done) begin
                    state_next = (miss_q.flushed || flush) ? IDLE : RESPOND;
                end
            end
            RESPOND: begin
                if (flush || !stall) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            miss_q  <= '0;
        end else begin
            state_q <= state_next;
            if (state_q == LOOKUP && state_next == MISS) begin
                miss_q.way     <= victim_way;
                miss_q.flushed <= 1'b0;
            end else if (flush && (state_q == MISS || state_q == REFILL)) begin
                // Burst keeps going, only the response is dropped
                miss_q.flushed <= 1'b1;
            end
            if (beat) begin
                miss_q.line[beat_idx] <= mem_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    assign start_off = addr_off(req_q.start_addr);
    assign src_line  = (state_q == RESPOND) ? miss_q.line : rd_line;

    // Rotate so that word 0 is the start word
    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            resp.line[i] = src_line[start_off + word_off_t'(i)];
        end
        resp.mask       = word_mask_t'((9'd1 << req_q.count) - 9'd1);
        resp.start_addr = req_q.start_addr;
    end

    assign resp_valid = lookup_hit || (state_q == RESPOND);

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int num_sets = icache_pkg::num_sets
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_en,
    input  fetch_req_t  req,
    output logic        req_ready,
    input  logic        flush,
    input  logic        stall,
    output logic        resp_valid,
    output fetch_resp_t resp,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ready,
    input  logic        mem_valid,
    input  word_t       mem_data,
    input  logic        mem_last
);

    logic       rd_en;
    set_idx_t   rd_set;
    tag_t       rd_tag;
    logic [1:0] hit;
    logic       hit_way;
    line_t      rd_line;
    logic       victim_way;
    logic       wr_en;
    logic       wr_way;
    set_idx_t   wr_set;
    tag_t       wr_tag;
    line_t      wr_line;
    logic       clear;
    logic       beat;
    word_off_t  beat_idx;
    logic       last_beat;

    icache_ctrl #(
        .num_sets (num_sets)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_en     (req_en),
        .req        (req),
        .req_ready  (req_ready),
        .flush      (flush),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp       (resp),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .mem_last   (mem_last),
        .rd_en      (rd_en),
        .rd_set     (rd_set),
        .rd_tag     (rd_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .rd_line    (rd_line),
        .victim_way (victim_way),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_set     (wr_set),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .clear      (clear),
        .beat       (beat),
        .beat_idx   (beat_idx),
        .last_beat  (last_beat)
    );

    icache_way_array #(
        .num_sets (num_sets)
    ) u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .rd_set     (rd_set),
        .rd_tag     (rd_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .rd_line    (rd_line),
        .victim_way (victim_way),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_set     (wr_set),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line)
    );

    refill_counter u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .beat      (beat),
        .beat_idx  (beat_idx),
        .last_beat (last_beat)
    );

endmodule

`default_nettype wire

/* tests/icache_assert.sv */
`default_nettype none

module icache_ctrl_assert
    import icache_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        mem_req,
    input logic        mem_ready,
    input logic        flush,
    input logic        stall,
    input logic        resp_valid,
    input fetch_resp_t resp,
    input logic        wr_en,
    input logic        beat,
    input logic        mem_last
);

    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;

    // Request level stays up until memory takes the address
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n) mem_req && !mem_ready |=> mem_req
    ) else begin
        $error("mem_req dropped before mem_ready");
        fails++;
    end

    // One address handshake per miss
    a_mem_req_once: assert property (
        @(posedge clk) disable iff (!rst_n) mem_req && mem_ready |=> !mem_req
    ) else begin
        $error("mem_req still high after the address was accepted");
        fails++;
    end

    // A stalled response keeps its value until the predecode side takes it
    a_resp_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && stall && !flush |=> resp_valid && $stable(resp)
    ) else begin
        $error("response changed while stall was high");
        fails++;
    end

    a_write_on_last: assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> beat && mem_last
    ) else begin
        $error("array written before the last beat of the burst");
        fails++;
    end

endmodule

bind icache_ctrl icache_ctrl_assert u_ctrl_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .flush      (flush),
    .stall      (stall),
    .resp_valid (resp_valid),
    .resp       (resp),
    .wr_en      (wr_en),
    .beat       (beat),
    .mem_last   (mem_last)
);

`default_nettype wire

/* tests/icache_tb.sv */
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_en;
    fetch_req_t  req;
    logic        req_ready;
    logic        flush;
    logic        stall;
    logic        resp_valid;
    fetch_resp_t resp;
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_ready = 1'b0;
    logic        mem_valid = 1'b0;
    word_t       mem_data = '0;
    logic        mem_last = 1'b0;

    // Memory model state
    integer seed = 59;
    logic   in_burst = 1'b0;
    int     beat_n = 0;
    int     delay = 0;
    addr_t  mem_base = '0;
    int     bursts = 0;

    int checks = 0;
    int errors = 0;

    always #4 clk = ~clk;

    icache_top #(
        .num_sets (num_sets)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_en     (req_en),
        .req        (req),
        .req_ready  (req_ready),
        .flush      (flush),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp       (resp),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .mem_last   (mem_last)
    );

    function automatic word_t model_word(input addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    // Burst memory with a random ready delay and random gaps between beats
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            mem_valid <= 1'b0;
            mem_last  <= 1'b0;
            in_burst  <= 1'b0;
            delay     <= $random(seed) & 3;
        end else if (!in_burst) begin
            if (mem_req && mem_ready) begin
                mem_ready <= 1'b0;
                mem_base  <= mem_addr;
                in_burst  <= 1'b1;
                beat_n    <= 0;
                bursts    <= bursts + 1;
                delay     <= $random(seed) & 1;
            end else if (mem_req && delay == 0) begin
                mem_ready <= 1'b1;
            end else if (mem_req) begin
                delay <= delay - 1;
            end
        end else if (delay != 0) begin
            mem_valid <= 1'b0;
            mem_last  <= 1'b0;
            delay     <= delay - 1;
        end else if (beat_n < line_words) begin
            mem_valid <= 1'b1;
            mem_data  <= model_word(mem_base + addr_t'(4 * beat_n));
            mem_last  <= (beat_n == line_words - 1);
            beat_n    <= beat_n + 1;
            delay     <= $random(seed) & 1;
        end else begin
            mem_valid <= 1'b0;
            mem_last  <= 1'b0;
            in_burst  <= 1'b0;
            delay     <= $random(seed) & 3;
        end
    end

    // Words from the start address onward, one mask bit per instruction
    function automatic fetch_resp_t expect_resp(input addr_t start, input int count);
        fetch_resp_t r;
        r = '0;
        r.start_addr = start;
        for (int i = 0; i < count; i++) begin
            r.line[i] = model_word(start + addr_t'(4 * i));
            r.mask[i] = 1'b1;
        end
        return r;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_resp(input fetch_resp_t got, input fetch_resp_t exp, input string msg);
        checks++;
        if (got.mask !== exp.mask || got.start_addr !== exp.start_addr) begin
            errors++;
            $display("Mismatch at %0t: %s mask/addr got %h/%h expected %h/%h", $time, msg,
                     got.mask, got.start_addr, exp.mask, exp.start_addr);
        end
        for (int i = 0; i < line_words; i++) begin
            if (exp.mask[i] && got.line[i] !== exp.line[i]) begin
                errors++;
                $display("Mismatch at %0t: %s word %0d got %h expected %h", $time, msg, i,
                         got.line[i], exp.line[i]);
            end
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    // Returns on the edge that accepts the request
    task automatic send_req(input addr_t addr, input int count);
        int n;
        @(posedge clk);
        req_en <= 1'b1;
        req    <= '{start_addr: addr, count: 4'(count)};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!req_ready && n < timeout_cycles);
        if (!req_ready) begin
            report_timeout("req_ready");
        end
        @(posedge clk);
        req_en <= 1'b0;
    endtask

    task automatic wait_resp(output fetch_resp_t got, output int lat);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid && lat < timeout_cycles);
        if (!resp_valid) begin
            report_timeout("resp_valid");
        end
        got = resp;
    endtask

    task automatic fetch_block(input addr_t addr, input int count, input logic exp_hit,
                               input string name);
        fetch_resp_t got;
        int          lat;
        int          bursts_before;
        bursts_before = bursts;
        send_req(addr, count);
        wait_resp(got, lat);
        if (exp_hit) begin
            check_bit(lat == 1, 1'b1, {name, " hit latency of one cycle"});
            check_bit(mem_req, 1'b0, {name, " mem_req on hit"});
        end
        check_bit(bursts == bursts_before + (exp_hit ? 0 : 1), 1'b1, {name, " burst count"});
        check_resp(got, expect_resp(addr, count), name);
    endtask

    // Response must sit unchanged under stall, then leave once stall drops
    task automatic hold_resp(input fetch_resp_t exp, input int cycles, input string name);
        repeat (cycles) begin
            @(negedge clk);
            check_bit(resp_valid, 1'b1, {name, " valid under stall"});
            check_resp(resp, exp, {name, " under stall"});
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_bit(resp_valid, 1'b1, {name, " valid at release"});
        check_resp(resp, exp, {name, " at release"});
        @(negedge clk);
        check_bit(resp_valid, 1'b0, {name, " valid after release"});
    endtask

    task automatic show_result(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        check_bit(req_ready, 1'b1, "req_ready after reset");
        check_bit(resp_valid, 1'b0, "resp_valid after reset");
        check_bit(mem_req, 1'b0, "mem_req after reset");
        show_result("reset", errs_before);
    endtask

    task automatic test_cold_miss();
        int errs_before;
        errs_before = errors;
        fetch_block(32'h0000_1048, 5, 1'b0, "cold miss");
        check_addr(mem_base, 32'h0000_1040, "cold miss line address");
        show_result("cold miss", errs_before);
    endtask

    task automatic test_hits();
        int errs_before;
        int bursts_before;
        errs_before = errors;
        fetch_block(32'h0000_1048, 5, 1'b1, "repeat hit");
        bursts_before = bursts;
        // Two hits accepted on consecutive edges
        @(posedge clk);
        req_en <= 1'b1;
        req    <= '{start_addr: 32'h0000_1040, count: 4'd8};
        @(negedge clk);
        check_bit(req_ready, 1'b1, "first of pair ready");
        @(posedge clk);
        req <= '{start_addr: 32'h0000_105C, count: 4'd1};
        @(negedge clk);
        check_bit(resp_valid, 1'b1, "first of pair valid");
        check_bit(req_ready, 1'b1, "second of pair ready");
        check_resp(resp, expect_resp(32'h0000_1040, 8), "first of pair");
        @(posedge clk);
        req_en <= 1'b0;
        @(negedge clk);
        check_bit(resp_valid, 1'b1, "second of pair valid");
        check_resp(resp, expect_resp(32'h0000_105C, 1), "second of pair");
        check_bit(bursts == bursts_before, 1'b1, "no burst on back-to-back hits");
        show_result("hits", errs_before);
    endtask

    // Lines A, B and C share set 5
    task automatic test_lru();
        int errs_before;
        errs_before = errors;
        fetch_block(32'h0000_20A8, 4, 1'b0, "lru A fill");
        fetch_block(32'h0000_40A0, 8, 1'b0, "lru B fill");
        fetch_block(32'h0000_20A8, 4, 1'b1, "lru A hit");
        fetch_block(32'h0000_60B0, 3, 1'b0, "lru C evicts B");
        fetch_block(32'h0000_20A8, 4, 1'b1, "lru A kept");
        fetch_block(32'h0000_40A0, 8, 1'b0, "lru B refetch");
        show_result("lru", errs_before);
    endtask

    task automatic test_stall();
        fetch_resp_t got;
        int          lat;
        int          errs_before;
        errs_before = errors;
        @(posedge clk);
        stall <= 1'b1;
        send_req(32'h0000_1048, 5);
        wait_resp(got, lat);
        check_resp(got, expect_resp(32'h0000_1048, 5), "stalled hit");
        hold_resp(expect_resp(32'h0000_1048, 5), 3, "stalled hit");
        // Miss that ends in RESPOND under stall
        @(posedge clk);
        stall <= 1'b1;
        send_req(32'h0000_5010, 4);
        wait_resp(got, lat);
        check_resp(got, expect_resp(32'h0000_5010, 4), "stalled miss");
        hold_resp(expect_resp(32'h0000_5010, 4), 3, "stalled miss");
        show_result("stall", errs_before);
    endtask

    task automatic test_flush();
        int n;
        int errs_before;
        errs_before = errors;
        send_req(32'h0000_3124, 6);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!mem_req && n < timeout_cycles);
        if (!mem_req) begin
            report_timeout("mem_req");
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        // Burst drains with no response
        n = 0;
        do begin
            @(negedge clk);
            check_bit(resp_valid, 1'b0, "resp_valid after flush");
            n++;
        end while (!req_ready && n < timeout_cycles);
        if (!req_ready) begin
            report_timeout("the flushed burst to drain");
        end
        fetch_block(32'h0000_3124, 6, 1'b1, "flushed line hit");
        show_result("flush", errs_before);
    endtask

    initial begin
        rst_n  = 1'b0;
        req_en = 1'b0;
        req    = '0;
        flush  = 1'b0;
        stall  = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_cold_miss();
        test_hits();
        test_lru();
        test_stall();
        test_flush();
        // Bound assertion failures count as errors too
        errors += dut.u_ctrl.u_ctrl_assert.fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/icache_pkg.sv
hw/icache_way_array.sv
hw/refill_counter.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/icache_assert.sv
tests/icache_tb.sv
